//--- pf_macros.svh
// Prefetcher width and depth defines
`ifndef PF_MACROS_SVH
`define PF_MACROS_SVH

// Address and data widths
`define PF_ADDR_W 32
`define PF_DATA_W 64

// Read ID width on the client side
`define PF_ID_W 4

// Block store entries, also sizes the return queues
`define PF_DEPTH 8

// Watchdog prescaler width
`define PF_WD_W 10

`endif

//--- pf_pkg.sv
// Prefetcher shared types
`default_nettype none

`include "pf_macros.svh"

package pf_pkg;

    typedef logic [`PF_ADDR_W-1:0] addr_t;
    typedef logic [`PF_DATA_W-1:0] data_t;
    typedef logic [`PF_ID_W-1:0] id_t;
    typedef logic [$clog2(`PF_DEPTH)-1:0] slot_t;
    typedef logic [$clog2(`PF_DEPTH):0] cnt_t;      // Counts 0..PF_DEPTH
    typedef logic [`PF_WD_W-1:0] wd_t;

    // Who asked for a DDR read
    typedef enum logic {
        op_demand   = 1'b0,
        op_prefetch = 1'b1
    } ar_op_e;

    // Client read request
    typedef struct packed {
        addr_t addr;
        id_t   id;
    } rd_req_t;

    // Client read response
    typedef struct packed {
        data_t data;
        id_t   id;
    } rd_rsp_t;

    // Master ID, points straight back at the owning store slot
    typedef struct packed {
        ar_op_e kind;
        slot_t  slot;
    } ddr_tag_t;

    typedef struct packed {
        addr_t      bar;            // Lowest address allowed for prefetch
        addr_t      limit;          // Highest address allowed for prefetch
        logic [3:0] window;         // Max unconsumed prefetches
        wd_t        wd_prescale;
    } pf_cfg_t;

endpackage

`default_nettype wire

//--- pf_fifo.sv
// Small synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module pf_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic resetN,
    input  wire logic in_valid,
    output logic      in_ready,
    input  T          in_data,
    output logic      out_valid,
    input  wire logic out_ready,
    output T          out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic push, pop;

    assign in_ready  = (count != DEPTH[$bits(count)-1:0]);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

//--- pf_watchdog.sv
// Idle watchdog
`timescale 1ns/1ps
`default_nettype none

module pf_watchdog
    import pf_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetN,
    input  wd_t       prescale,
    input  wire logic activity,
    output logic      timeout
);

    wd_t  pre_cnt;
    logic tick;
    logic idle_q;       // One tick already passed without activity

    assign tick = (pre_cnt >= prescale);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pre_cnt <= '0;
            idle_q  <= 1'b0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (activity) idle_q <= 1'b0;
            else if (tick) idle_q <= ~idle_q;   // Wraps back after a timeout
        end
    end

    // Second quiet tick
    assign timeout = tick && idle_q && !activity;

endmodule

`default_nettype wire

//--- pf_stride_learner.sv
// Stride learner (decode stage)
`timescale 1ns/1ps
`default_nettype none

module pf_stride_learner
    import pf_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetN,
    input  wire logic s_ar_fire,
    input  rd_req_t   s_ar,
    input  pf_cfg_t   cfg,
    input  wire logic ctrl_flush,
    input  wire logic timeout,
    input  wire logic pf_issued,
    input  cnt_t      outstanding,
    input  cnt_t      pf_count,
    output addr_t     pf_addr,
    output logic      pf_want,
    output logic      cleanup,
    output logic      store_flush
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARM,
        ST_ACTIVE,
        ST_CLEANUP
    } state_e;

    state_e state;
    id_t    id_q;
    addr_t  prev_addr;
    addr_t  stride;
    addr_t  diff;
    logic   stride_ok;      // One nonzero stride seen while arming
    logic   id_miss;
    logic   in_range;

    assign diff     = s_ar.addr - prev_addr;
    assign id_miss  = (s_ar.id != id_q);
    assign in_range = (pf_addr >= cfg.bar) && (pf_addr <= cfg.limit);

    assign cleanup     = (state == ST_CLEANUP);
    assign store_flush = cleanup && (outstanding == '0);   // Nothing left in flight
    assign pf_want     = (state == ST_ACTIVE) && in_range && (pf_count < cnt_t'(cfg.window));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state     <= ST_IDLE;
            stride_ok <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ctrl_flush) begin
                        state <= ST_CLEANUP;
                    end else if (s_ar_fire) begin
                        state     <= ST_ARM;
                        stride_ok <= 1'b0;
                    end
                end
                ST_ARM: begin
                    if (ctrl_flush || timeout || (s_ar_fire && id_miss)) begin
                        state <= ST_CLEANUP;
                    end else if (s_ar_fire && diff != '0) begin
                        if (stride_ok && diff == stride) state <= ST_ACTIVE;
                        stride_ok <= 1'b1;
                    end
                end
                ST_ACTIVE: begin
                    // Any break in the pattern drops the learned context
                    if (ctrl_flush || timeout || (s_ar_fire && (id_miss || diff != stride)))
                        state <= ST_CLEANUP;
                end
                ST_CLEANUP: begin
                    if (store_flush) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s_ar_fire) prev_addr <= s_ar.addr;
        if (state == ST_IDLE && s_ar_fire) id_q <= s_ar.id;

        if (state == ST_ARM && s_ar_fire && diff != '0) begin
            stride  <= diff;
            pf_addr <= s_ar.addr + diff;    // First block ahead of the client
        end else if (pf_issued) begin
            pf_addr <= pf_addr + stride;
        end
    end

endmodule

`default_nettype wire

//--- pf_req_exec.sv
// Request executor (execute stage)
`timescale 1ns/1ps
`default_nettype none

module pf_req_exec
    import pf_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetN,

    // Slave AR
    input  wire logic s_ar_valid,
    output logic      s_ar_ready,
    input  rd_req_t   s_ar,

    // Store lookup and slot grant
    input  wire logic hit,
    input  slot_t     hit_slot,
    input  slot_t     free_slot,
    input  wire logic slot_avail,

    // From the learner
    input  addr_t     pf_addr,
    input  wire logic pf_want,
    input  wire logic cleanup,

    input  wire logic rfifo_ready,
    input  wire logic m_r_fire,

    // Master AR
    output logic      m_ar_valid,
    input  wire logic m_ar_ready,
    output addr_t     m_ar_addr,
    output ddr_tag_t  m_ar_id,

    // Slot claim
    output logic      alloc_valid,
    output slot_t     alloc_slot,
    output addr_t     alloc_addr,
    output ar_op_e    alloc_op,
    output id_t       alloc_id,

    output logic      pf_issued,
    output cnt_t      outstanding,
    output logic      activity,

    input  wd_t       wd_prescale,
    output logic      timeout
);

    logic s_ar_fire;
    logic m_ar_fire;
    logic dm_launch;    // Demand miss goes to DDR
    logic pf_launch;
    logic launch;

    assign s_ar_fire = s_ar_valid && s_ar_ready;
    assign m_ar_fire = m_ar_valid && m_ar_ready;

    // A hit needs no DDR slot, a miss needs a free slot and an idle AR channel
    assign s_ar_ready = !cleanup && rfifo_ready && (hit || (!m_ar_valid && slot_avail));

    assign dm_launch = s_ar_fire && !hit;
    assign pf_launch = pf_want && !cleanup && !s_ar_fire && !m_ar_valid && slot_avail;
    assign launch    = dm_launch || pf_launch;

    // Hits reclaim their slot as demand, misses and prefetches take a free one
    assign alloc_valid = s_ar_fire || pf_launch;
    assign alloc_op    = pf_launch ? op_prefetch : op_demand;
    assign alloc_slot  = (s_ar_fire && hit) ? hit_slot : free_slot;
    assign alloc_addr  = pf_launch ? pf_addr : s_ar.addr;
    assign alloc_id    = s_ar.id;

    assign pf_issued = m_ar_fire && (m_ar_id.kind == op_prefetch);
    assign activity  = s_ar_fire || launch || m_ar_fire || m_r_fire;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            m_ar_valid  <= 1'b0;
            outstanding <= '0;
        end else begin
            if (launch) m_ar_valid <= 1'b1;
            else if (m_ar_fire) m_ar_valid <= 1'b0;
            // Counted from the claim, so a read still waiting on AR is covered
            outstanding <= outstanding + cnt_t'(launch) - cnt_t'(m_r_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            m_ar_addr <= alloc_addr;
            m_ar_id   <= '{kind: alloc_op, slot: alloc_slot};
        end
    end

    pf_watchdog i_watchdog (
        .clk      (clk),
        .resetN   (resetN),
        .prescale (wd_prescale),
        .activity (activity),
        .timeout  (timeout)
    );

endmodule

`default_nettype wire

//--- pf_block_store.sv
// Tagged block store and read return path (result stage)
`timescale 1ns/1ps
`default_nettype none

`include "pf_macros.svh"

module pf_block_store
    import pf_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetN,
    input  addr_t     lookup_addr,
    output logic      hit,
    output slot_t     hit_slot,
    output slot_t     free_slot,
    output logic      slot_avail,
    input  wire logic alloc_valid,
    input  slot_t     alloc_slot,
    input  addr_t     alloc_addr,
    input  ar_op_e    alloc_op,
    input  id_t       alloc_id,
    input  wire logic store_flush,
    input  wire logic m_r_valid,
    output logic      m_r_ready,
    input  data_t     m_r_data,
    input  ddr_tag_t  m_r_id,
    output cnt_t      pf_count,
    output logic      rfifo_ready,
    output logic      s_r_valid,
    input  wire logic s_r_ready,
    output rd_rsp_t   s_r
);

    localparam int DEPTH = `PF_DEPTH;

    logic [DEPTH-1:0] valid, filled, dm;   // dm marks a slot owed to the client
    addr_t   tag [DEPTH];
    id_t     sid [DEPTH];
    data_t   data_mem [DEPTH];
    logic    m_r_fire;
    rd_req_t head;                          // Oldest demand still owed
    logic    head_valid;
    logic    drain_hit, drain;
    slot_t   drain_slot;
    rd_rsp_t rsp_q;
    logic    rsp_v;
    logic    r_in_ready;

    assign m_r_ready   = 1'b1;     // Every DDR read already owns its slot
    assign m_r_fire    = m_r_valid && m_r_ready;
    assign rfifo_ready = r_in_ready;

    always_comb begin
        hit        = 1'b0;
        hit_slot   = '0;
        free_slot  = '0;
        slot_avail = 1'b0;
        pf_count   = '0;
        for (int i = DEPTH-1; i >= 0; i--) begin
            if (valid[i] && !dm[i] && tag[i] == lookup_addr) begin
                hit      = 1'b1;
                hit_slot = slot_t'(i);
            end
            if (!valid[i]) begin
                slot_avail = 1'b1;
                free_slot  = slot_t'(i);
            end
            if (valid[i] && !dm[i]) pf_count = pf_count + 1'b1;
        end
    end

    // Find the filled slot that answers the oldest demand
    always_comb begin
        drain_hit  = 1'b0;
        drain_slot = '0;
        for (int i = DEPTH-1; i >= 0; i--) begin
            if (valid[i] && dm[i] && filled[i] && tag[i] == head.addr && sid[i] == head.id) begin
                drain_hit  = 1'b1;
                drain_slot = slot_t'(i);
            end
        end
    end

    assign drain = head_valid && drain_hit && (!rsp_v || r_in_ready);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            valid  <= '0;
            filled <= '0;
            dm     <= '0;
            rsp_v  <= 1'b0;
        end else begin
            if (store_flush) valid <= valid & dm;   // Demand entries survive a flush
            if (alloc_valid) begin
                valid[alloc_slot] <= 1'b1;
                dm[alloc_slot]    <= (alloc_op == op_demand);
                if (!valid[alloc_slot]) filled[alloc_slot] <= 1'b0;
            end
            if (m_r_fire) filled[m_r_id.slot] <= 1'b1;
            if (drain) valid[drain_slot] <= 1'b0;

            if (drain) rsp_v <= 1'b1;
            else if (r_in_ready) rsp_v <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            tag[alloc_slot] <= alloc_addr;
            sid[alloc_slot] <= alloc_id;
        end
        if (m_r_fire) data_mem[m_r_id.slot] <= m_r_data;
        if (drain) rsp_q <= '{data: data_mem[drain_slot], id: head.id};
    end

    // Demands in acceptance order
    pf_fifo #(.T(rd_req_t), .DEPTH(DEPTH)) i_pend_fifo (
        .clk       (clk),
        .resetN    (resetN),
        .in_valid  (alloc_valid && alloc_op == op_demand),
        .in_ready  (),
        .in_data   ('{addr: alloc_addr, id: alloc_id}),
        .out_valid (head_valid),
        .out_ready (drain),
        .out_data  (head)
    );

    pf_fifo #(.T(rd_rsp_t), .DEPTH(DEPTH)) i_r_fifo (
        .clk       (clk),
        .resetN    (resetN),
        .in_valid  (rsp_v),
        .in_ready  (r_in_ready),
        .in_data   (rsp_q),
        .out_valid (s_r_valid),
        .out_ready (s_r_ready),
        .out_data  (s_r)
    );

endmodule

`default_nettype wire

//--- pf_top.sv
// Stride prefetcher top level
`timescale 1ns/1ps
`default_nettype none

module pf_top
    import pf_pkg::*;
(
    input  wire logic clk,
    input  wire logic resetN,
    input  wire logic s_ar_valid,
    output logic      s_ar_ready,
    input  rd_req_t   s_ar,
    output logic      s_r_valid,
    input  wire logic s_r_ready,
    output rd_rsp_t   s_r,
    output logic      m_ar_valid,
    input  wire logic m_ar_ready,
    output addr_t     m_ar_addr,
    output ddr_tag_t  m_ar_id,
    input  wire logic m_r_valid,
    output logic      m_r_ready,
    input  data_t     m_r_data,
    input  ddr_tag_t  m_r_id,
    input  pf_cfg_t   cfg,
    input  wire logic ctrl_flush
);

    addr_t  pf_addr, alloc_addr;
    logic   pf_want, cleanup, store_flush, timeout, pf_issued;
    cnt_t   outstanding, pf_count;
    logic   hit, slot_avail, alloc_valid, rfifo_ready;
    slot_t  hit_slot, free_slot, alloc_slot;
    ar_op_e alloc_op;
    id_t    alloc_id;

    pf_stride_learner i_learner (
        .clk         (clk),
        .resetN      (resetN),
        .s_ar_fire   (s_ar_valid && s_ar_ready),
        .s_ar        (s_ar),
        .cfg         (cfg),
        .ctrl_flush  (ctrl_flush),
        .timeout     (timeout),
        .pf_issued   (pf_issued),
        .outstanding (outstanding),
        .pf_count    (pf_count),
        .pf_addr     (pf_addr),
        .pf_want     (pf_want),
        .cleanup     (cleanup),
        .store_flush (store_flush)
    );

    pf_req_exec i_exec (
        .clk         (clk),
        .resetN      (resetN),
        .s_ar_valid  (s_ar_valid),
        .s_ar_ready  (s_ar_ready),
        .s_ar        (s_ar),
        .hit         (hit),
        .hit_slot    (hit_slot),
        .free_slot   (free_slot),
        .slot_avail  (slot_avail),
        .pf_addr     (pf_addr),
        .pf_want     (pf_want),
        .cleanup     (cleanup),
        .rfifo_ready (rfifo_ready),
        .m_r_fire    (m_r_valid && m_r_ready),
        .m_ar_valid  (m_ar_valid),
        .m_ar_ready  (m_ar_ready),
        .m_ar_addr   (m_ar_addr),
        .m_ar_id     (m_ar_id),
        .alloc_valid (alloc_valid),
        .alloc_slot  (alloc_slot),
        .alloc_addr  (alloc_addr),
        .alloc_op    (alloc_op),
        .alloc_id    (alloc_id),
        .pf_issued   (pf_issued),
        .outstanding (outstanding),
        .activity    (),
        .wd_prescale (cfg.wd_prescale),
        .timeout     (timeout)
    );

    pf_block_store i_store (
        .clk         (clk),
        .resetN      (resetN),
        .lookup_addr (s_ar.addr),
        .hit         (hit),
        .hit_slot    (hit_slot),
        .free_slot   (free_slot),
        .slot_avail  (slot_avail),
        .alloc_valid (alloc_valid),
        .alloc_slot  (alloc_slot),
        .alloc_addr  (alloc_addr),
        .alloc_op    (alloc_op),
        .alloc_id    (alloc_id),
        .store_flush (store_flush),
        .m_r_valid   (m_r_valid),
        .m_r_ready   (m_r_ready),
        .m_r_data    (m_r_data),
        .m_r_id      (m_r_id),
        .pf_count    (pf_count),
        .rfifo_ready (rfifo_ready),
        .s_r_valid   (s_r_valid),
        .s_r_ready   (s_r_ready),
        .s_r         (s_r)
    );

endmodule

`default_nettype wire

//--- tb_pf_top.sv
// Stride prefetcher testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pf_top
    import pf_pkg::*;
;

    // About 1000 cycles of tests, three times that for margin
    localparam int CYCLE_LIMIT = 3000;
    localparam int DDR_LAT = 6;

    logic clk, resetN;
    logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
    rd_req_t s_ar;
    rd_rsp_t s_r;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
    addr_t m_ar_addr;
    ddr_tag_t m_ar_id, m_r_id;
    data_t m_r_data;
    pf_cfg_t cfg;
    logic ctrl_flush;

    logic [31:0] seed = 32'hf6d8_2646;
    int errors = 0;
    int tests = 0;
    int cyc = 0;
    addr_t ar_addr_q [$];     // Every accepted master AR
    ddr_tag_t ar_tag_q [$];
    addr_t pend_addr [$];     // DDR model reads in flight
    ddr_tag_t pend_tag [$];
    int pend_due [$];

    logic ar_fire_s = 1'b0;   // Master handshakes seen before the edge
    logic r_fire_s = 1'b0;
    addr_t ar_addr_s;
    ddr_tag_t ar_tag_s;

    pf_top i_pf_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Master channels are stable at the falling edge
    always @(negedge clk) begin
        ar_fire_s = m_ar_valid && m_ar_ready;
        ar_addr_s = m_ar_addr;
        ar_tag_s  = m_ar_id;
        r_fire_s  = m_r_valid && m_r_ready;
    end

    // DDR model, fixed latency, always ready
    always @(posedge clk) begin
        cyc++;
        if (r_fire_s) begin
            void'(pend_addr.pop_front());
            void'(pend_tag.pop_front());
            void'(pend_due.pop_front());
        end
        if (ar_fire_s) begin
            ar_addr_q.push_back(ar_addr_s);
            ar_tag_q.push_back(ar_tag_s);
            pend_addr.push_back(ar_addr_s);
            pend_tag.push_back(ar_tag_s);
            pend_due.push_back(cyc + DDR_LAT);
        end
        #1;
        if (pend_addr.size() != 0 && pend_due[0] <= cyc) begin
            m_r_valid = 1'b1;
            m_r_data  = model_data(pend_addr[0]);
            m_r_id    = pend_tag[0];
        end else begin
            m_r_valid = 1'b0;
        end
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic data_t model_data(addr_t addr);
        return data_t'(addr) ^ 64'hA5A5_0000_5A5A_0000;
    endfunction

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_rsp(string name, rd_rsp_t got, rd_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ar(string name, addr_t got_addr, ddr_tag_t got_tag,
                            addr_t exp_addr, ar_op_e exp_kind);
        if (got_addr !== exp_addr || got_tag.kind !== exp_kind) begin
            errors++;
            $display("Mismatch %s: got %h/%h expected %h/%h", name, got_addr,
                     got_tag.kind, exp_addr, exp_kind);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests++;
        $display("%-14s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // Single read, waits for acceptance and the response
    task automatic do_read(input addr_t addr, input id_t id, output rd_rsp_t rsp,
                           output int lat);
        s_ar_valid = 1'b1;
        s_ar = '{addr: addr, id: id};
        @(negedge clk);
        while (!s_ar_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1 s_ar_valid = 1'b0;
        lat = 0;
        @(negedge clk);
        while (!s_r_valid) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        rsp = s_r;
        @(posedge clk);
        #1;
    endtask

    task automatic read_check(addr_t addr, id_t id, output int lat);
        rd_rsp_t rsp;
        do_read(addr, id, rsp, lat);
        check_rsp("s_r", rsp, '{data: model_data(addr), id: id});
    endtask

    task automatic settle();
        while (pend_addr.size() != 0 || m_ar_valid) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic flush_ctx();
        settle();
        ctrl_flush = 1'b1;
        @(posedge clk);
        #1 ctrl_flush = 1'b0;
        settle();
    endtask

    task automatic pick_stream(output addr_t base, output addr_t stride);
        base   = 32'h1000_0000 | (lcg_next() & 32'h00FF_FFF8);
        stride = addr_t'(((lcg_next() >> 4) & 32'hF) + 1) << 3;
    endtask

    // Three reads with one stride arm the learner
    task automatic train(addr_t base, addr_t stride);
        int lat;
        for (int k = 0; k < 3; k++) read_check(base + k * stride, 4'h5, lat);
        settle();
    endtask

    function automatic int count_ars(int from, ar_op_e kind, logic any_addr, addr_t addr);
        int n = 0;
        for (int i = from; i < ar_addr_q.size(); i++)
            if (ar_tag_q[i].kind == kind && (any_addr || ar_addr_q[i] == addr)) n++;
        return n;
    endfunction

    // Valid outputs low and DDR return open out of reset
    task automatic test_reset();
        int e = errors;
        check_flag("s_r_valid", s_r_valid, 1'b0);
        check_flag("m_ar_valid", m_ar_valid, 1'b0);
        check_flag("m_r_ready", m_r_ready, 1'b1);
        report_test("reset", e);
    endtask

    task automatic test_demand_miss();
        int e = errors;
        int mark;
        int lat;
        addr_t a;
        flush_ctx();
        a = 32'h1000_0000 | (lcg_next() & 32'h00FF_FFF8);
        mark = ar_addr_q.size();
        read_check(a, 4'h3, lat);
        check_count("master ARs", ar_addr_q.size() - mark, 1);
        if (ar_addr_q.size() > mark)
            check_ar("m_ar", ar_addr_q[mark], ar_tag_q[mark], a, op_demand);
        report_test("demand_miss", e);
    endtask

    // Also leaves an armed stream behind for the hit test
    task automatic test_stride(output addr_t b, output addr_t s);
        int e = errors;
        int mark;
        flush_ctx();
        pick_stream(b, s);
        mark = ar_addr_q.size();
        train(b, s);
        check_count("prefetch ARs", ar_addr_q.size() - mark - 3, cfg.window);
        for (int i = mark + 3; i < ar_addr_q.size(); i++)
            check_ar("m_ar", ar_addr_q[i], ar_tag_q[i], b + (i - mark) * s, op_prefetch);
        report_test("stride", e);
    endtask

    task automatic test_hit(addr_t b, addr_t s);
        int e = errors;
        int mark = ar_addr_q.size();
        int lat;
        for (int k = 3; k < 6; k++) begin
            read_check(b + k * s, 4'h5, lat);
            check_count("hit latency", lat, 2);
        end
        settle();
        check_count("demand ARs", count_ars(mark, op_demand, 1'b1, '0), 0);
        report_test("hit", e);
    endtask

    task automatic test_range();
        int e = errors;
        int mark;
        addr_t b, s;
        flush_ctx();
        pick_stream(b, s);
        cfg.limit = b + 4 * s;
        mark = ar_addr_q.size();
        train(b, s);
        check_count("prefetch ARs", count_ars(mark, op_prefetch, 1'b1, '0), 2);
        for (int i = mark; i < ar_addr_q.size(); i++)
            if (ar_addr_q[i] > cfg.limit) begin
                errors++;
                $display("Prefetch went past the limit address");
            end
        flush_ctx();
        cfg.limit = 32'h1FFF_FFFF;
        report_test("range", e);
    endtask

    // Id change, stride break and external flush
    task automatic test_break();
        int e = errors;
        int mark;
        int lat;
        addr_t b, s;
        for (int mode = 0; mode < 3; mode++) begin
            flush_ctx();
            pick_stream(b, s);
            train(b, s);
            mark = ar_addr_q.size();
            if (mode == 0) read_check(b + 32'h10000, 4'h9, lat);
            else if (mode == 1) read_check(b + 32'h10000, 4'h5, lat);
            else flush_ctx();
            settle();
            read_check(b + 4 * s, 4'h5, lat);
            check_count("prefetch ARs", count_ars(mark, op_prefetch, 1'b1, '0), 0);
            check_count("refetch ARs", count_ars(mark, op_demand, 1'b0, b + 4 * s), 1);
        end
        report_test("break", e);
    endtask

    task automatic test_watchdog();
        int e = errors;
        int mark;
        int lat;
        addr_t b, s;
        flush_ctx();
        cfg.wd_prescale = wd_t'(20);
        pick_stream(b, s);
        train(b, s);
        repeat (120) @(posedge clk);   // Well over two ticks
        #1;
        mark = ar_addr_q.size();
        read_check(b + 3 * s, 4'h5, lat);
        check_count("refetch ARs", count_ars(mark, op_demand, 1'b0, b + 3 * s), 1);
        report_test("watchdog", e);
    endtask

    initial begin
        addr_t b, s;
        resetN = 1'b0;
        s_ar_valid = 1'b0;
        s_ar = '0;
        s_r_ready = 1'b1;
        m_ar_ready = 1'b1;
        m_r_valid = 1'b0;
        m_r_data = '0;
        m_r_id = '0;
        ctrl_flush = 1'b0;
        cfg = '{bar: 32'h1000_0000, limit: 32'h1FFF_FFFF, window: 4'd4,
                wd_prescale: wd_t'(300)};
        repeat (10) @(posedge clk);
        #1 resetN = 1'b1;
        test_reset();
        test_demand_miss();
        test_stride(b, s);
        test_hit(b, s);
        test_range();
        test_break();
        test_watchdog();
        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
pf_pkg.sv
pf_fifo.sv
pf_watchdog.sv
pf_stride_learner.sv
pf_req_exec.sv
pf_block_store.sv
pf_top.sv
tb_pf_top.sv

//--- Bender.yml
package:
  name: pf_prefetcher

sources:
  - include_dirs:
      - .
    files:
      - pf_pkg.sv
      - pf_fifo.sv
      - pf_watchdog.sv
      - pf_stride_learner.sv
      - pf_req_exec.sv
      - pf_block_store.sv
      - pf_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pf_top.sv
